//--- hw/ahb_bridge_config.svh
`ifndef AHB_BRIDGE_CONFIG_SVH
`define AHB_BRIDGE_CONFIG_SVH

// Width of HADDR in bits.
`define AHB_ADDR_WIDTH 32

// Width of HWDATA and HRDATA in bits. 32, 64 and 128 are supported.
`define AHB_DATA_WIDTH 64

// Number of data words in the SRAM, a power of two.
`define MEM_DEPTH 512

`endif

//--- hw/ahb_bridge_pkg.sv
`include "ahb_bridge_config.svh"

package ahb_bridge_pkg;

    // AHB transfer types as carried on HTRANS.
    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_BUSY   = 2'b01,
        HTRANS_NONSEQ = 2'b10,
        HTRANS_SEQ    = 2'b11
    } htrans_e;

    // AHB transfer sizes as carried on HSIZE.
    typedef enum logic [2:0] {
        HSIZE_BYTE   = 3'b000,
        HSIZE_HALF   = 3'b001,
        HSIZE_WORD   = 3'b010,
        HSIZE_DWORD  = 3'b011,
        HSIZE_LINE4  = 3'b100,
        HSIZE_LINE8  = 3'b101,
        HSIZE_LINE16 = 3'b110,
        HSIZE_LINE32 = 3'b111
    } hsize_e;

    localparam int LANES     = `AHB_DATA_WIDTH / 8;
    localparam int LANE_BITS = $clog2(LANES);
    localparam int WADDR_BITS = $clog2(`MEM_DEPTH);

    typedef logic [`AHB_DATA_WIDTH-1:0] data_t;
    typedef logic [LANES-1:0]           byteen_t;
    typedef logic [WADDR_BITS-1:0]      word_addr_t;

endpackage

//--- hw/mem_req_if.sv
`timescale 1ns/1ps

interface mem_req_if (
    input logic s_ahb
);
    import ahb_bridge_pkg::*;

    // Write request, valid during the data phase of an AHB write.
    logic       wr_en;
    word_addr_t wr_addr;
    data_t      wr_data;
    byteen_t    wr_byteen;

    // Read request, valid during the address phase of an AHB read.
    logic       rd_en;
    word_addr_t rd_addr;

    modport decode (
        input  s_ahb,
        output wr_en,
        output wr_addr,
        output wr_data,
        output wr_byteen,
        output rd_en,
        output rd_addr
    );

    modport execute (
        input  s_ahb,
        input  wr_en,
        input  wr_addr,
        input  wr_data,
        input  wr_byteen,
        input  rd_en,
        input  rd_addr
    );

    modport monitor (
        input  s_ahb,
        input  wr_en,
        input  wr_addr,
        input  wr_data,
        input  wr_byteen,
        input  rd_addr
    );

endinterface

//--- hw/ahb_addr_decode.sv
`timescale 1ns/1ps
`include "ahb_bridge_config.svh"

module ahb_addr_decode (
    input  logic                         s_ahb,
    input  logic                         rst,
    input  logic                         hsel,
    input  logic [`AHB_ADDR_WIDTH-1:0]   haddr,
    input  ahb_bridge_pkg::htrans_e      htrans,
    input  logic                         hwrite,
    input  ahb_bridge_pkg::hsize_e       hsize,
    input  ahb_bridge_pkg::data_t        hwdata,
    mem_req_if.decode                    req
);
    import ahb_bridge_pkg::*;

    logic                 active;
    logic                 wr_start;
    logic [LANE_BITS-1:0] lane_off;
    int unsigned          lane_cnt;
    word_addr_t           word_addr;
    byteen_t              lane_mask;

    logic                 wr_en_q;
    word_addr_t           wr_addr_q;
    byteen_t              wr_byteen_q;

    // Only NONSEQ and SEQ carry a transfer; IDLE and BUSY are ignored.
    assign active   = hsel && (htrans == HTRANS_NONSEQ || htrans == HTRANS_SEQ);
    assign wr_start = active && hwrite;

    // Out-of-range addresses wrap modulo the memory depth.
    assign lane_off  = haddr[LANE_BITS-1:0];
    assign word_addr = haddr[LANE_BITS +: WADDR_BITS];

    // Lanes run from the byte offset for 2**hsize bytes and stop at the top lane.
    always_comb begin
        lane_cnt = 32'd1 << hsize;
        for (int j = 0; j < LANES; j++) begin
            lane_mask[j] = (j >= int'(lane_off)) && (j < int'(lane_off) + int'(lane_cnt));
        end
    end

    always_ff @(posedge s_ahb) begin
        if (rst) begin
            wr_en_q     <= 1'b0;
            wr_byteen_q <= '0;
        end else begin
            wr_en_q     <= wr_start;
            wr_byteen_q <= wr_start ? lane_mask : '0;
        end
    end

    always_ff @(posedge s_ahb) begin
        if (wr_start) begin
            wr_addr_q <= word_addr;
        end
    end

    // Reads go out in the address phase.
    assign req.rd_en   = active && !hwrite;
    assign req.rd_addr = word_addr;

    // Writes meet their data one cycle later.
    assign req.wr_en     = wr_en_q;
    assign req.wr_addr   = wr_addr_q;
    assign req.wr_byteen = wr_byteen_q;
    assign req.wr_data   = hwdata;

endmodule

//--- hw/byte_lane_sram.sv
`timescale 1ns/1ps
`include "ahb_bridge_config.svh"

module byte_lane_sram (
    input  logic                   s_ahb,
    mem_req_if.execute             req,
    output ahb_bridge_pkg::data_t  rd_data
);
    import ahb_bridge_pkg::*;

    logic [LANES-1:0][7:0] mem [`MEM_DEPTH];
    logic [LANES-1:0][7:0] wr_bytes;

    assign wr_bytes = req.wr_data;

    // Each lane has its own write enable.
    always_ff @(posedge s_ahb) begin
        if (req.wr_en) begin
            for (int i = 0; i < LANES; i++) begin
                if (req.wr_byteen[i]) begin
                    mem[req.wr_addr][i] <= wr_bytes[i];
                end
            end
        end
    end

    // A read in the same cycle as a write to that word sees the old content.
    always_ff @(posedge s_ahb) begin
        if (req.rd_en) begin
            rd_data <= mem[req.rd_addr];
        end
    end

endmodule

//--- hw/read_forward_merge.sv
`timescale 1ns/1ps

module read_forward_merge (
    input  logic                   s_ahb,
    input  logic                   rst,
    mem_req_if.monitor             req,
    input  logic                   rd_en,
    input  ahb_bridge_pkg::data_t  mem_data,
    output ahb_bridge_pkg::data_t  hrdata
);
    import ahb_bridge_pkg::*;

    logic    same_word;
    logic    hit_q;
    logic    rd_seen_q;
    byteen_t fwd_lanes_q;
    data_t   fwd_data_q;
    data_t   merged;

    // The SRAM returns old data here, so the write bytes are kept aside.
    assign same_word = req.wr_en && (req.wr_addr == req.rd_addr);

    always_ff @(posedge s_ahb) begin
        if (rst) begin
            hit_q     <= 1'b0;
            rd_seen_q <= 1'b0;
        end else if (rd_en) begin
            hit_q     <= same_word;
            rd_seen_q <= 1'b1;
        end
    end

    always_ff @(posedge s_ahb) begin
        if (rd_en) begin
            fwd_lanes_q <= req.wr_byteen;
            fwd_data_q  <= req.wr_data;
        end
    end

    always_comb begin
        merged = mem_data;
        for (int i = 0; i < LANES; i++) begin
            if (hit_q && fwd_lanes_q[i]) begin
                merged[i*8 +: 8] = fwd_data_q[i*8 +: 8];
            end
        end
    end

    // Nothing has been read yet right after reset.
    assign hrdata = rd_seen_q ? merged : '0;

endmodule

//--- hw/ahb_mem_bridge.sv
`timescale 1ns/1ps
`include "ahb_bridge_config.svh"

module ahb_mem_bridge (
    input  logic                         s_ahb,
    input  logic                         rst,
    input  logic                         hsel,
    input  logic [`AHB_ADDR_WIDTH-1:0]   haddr,
    input  logic [1:0]                   htrans,
    input  logic                         hwrite,
    input  logic [2:0]                   hsize,
    input  logic [`AHB_DATA_WIDTH-1:0]   hwdata,
    output logic [`AHB_DATA_WIDTH-1:0]   hrdata
);
    import ahb_bridge_pkg::*;

    htrans_e trans_type;
    hsize_e  trans_size;
    data_t   mem_data;

    assign trans_type = htrans_e'(htrans);
    assign trans_size = hsize_e'(hsize);

    mem_req_if req_if (
        .s_ahb (s_ahb)
    );

    ahb_addr_decode u_decode (
        .s_ahb  (s_ahb),
        .rst    (rst),
        .hsel   (hsel),
        .haddr  (haddr),
        .htrans (trans_type),
        .hwrite (hwrite),
        .hsize  (trans_size),
        .hwdata (hwdata),
        .req    (req_if.decode)
    );

    byte_lane_sram u_sram (
        .s_ahb   (s_ahb),
        .req     (req_if.execute),
        .rd_data (mem_data)
    );

    // Read data is valid in the data phase, one cycle after the address phase.
    read_forward_merge u_merge (
        .s_ahb    (s_ahb),
        .rst      (rst),
        .req      (req_if.monitor),
        .rd_en    (req_if.rd_en),
        .mem_data (mem_data),
        .hrdata   (hrdata)
    );

endmodule

//--- verification/ahb_mem_bridge_chk.sv
`timescale 1ns/1ps

module ahb_mem_bridge_chk (
    input logic                    s_ahb,
    input logic                    rst,
    input logic                    hsel,
    input ahb_bridge_pkg::htrans_e htrans,
    input logic                    hwrite,
    input logic                    wr_en,
    input ahb_bridge_pkg::byteen_t wr_byteen,
    input logic                    rd_en
);
    import ahb_bridge_pkg::*;

    int unsigned fail_count = 0;
    logic        wr_qual;

    assign wr_qual = hsel && hwrite && (htrans == HTRANS_NONSEQ || htrans == HTRANS_SEQ);

    // A write strobe always carries at least one lane.
    wr_has_lanes: assert property (@(posedge s_ahb) disable iff (rst)
        wr_en |-> wr_byteen != '0)
        else begin
            $error("wr_en is high with no byte lane enabled");
            fail_count++;
        end

    // The data phase follows a qualified write address phase, and nothing else.
    wr_after_qual: assert property (@(posedge s_ahb) disable iff (rst)
        wr_en |-> $past(wr_qual))
        else begin
            $error("wr_en is high without a qualified write in the previous cycle");
            fail_count++;
        end

    qual_gives_wr: assert property (@(posedge s_ahb) disable iff (rst)
        wr_qual |=> wr_en)
        else begin
            $error("qualified write was not followed by wr_en");
            fail_count++;
        end

    rd_needs_hsel: assert property (@(posedge s_ahb) disable iff (rst)
        rd_en |-> hsel)
        else begin
            $error("rd_en is high while hsel is low");
            fail_count++;
        end

    quiet_in_reset: assert property (@(posedge s_ahb)
        rst && $past(rst) |-> !wr_en && !rd_en)
        else begin
            $error("request issued during reset");
            fail_count++;
        end

endmodule

bind ahb_addr_decode ahb_mem_bridge_chk chk0 (
    .s_ahb     (s_ahb),
    .rst       (rst),
    .hsel      (hsel),
    .htrans    (htrans),
    .hwrite    (hwrite),
    .wr_en     (req.wr_en),
    .wr_byteen (req.wr_byteen),
    .rd_en     (req.rd_en)
);

//--- verification/ahb_mem_bridge_tb.sv
`timescale 1ns/1ps
`include "ahb_bridge_config.svh"

module ahb_mem_bridge_tb;
    import ahb_bridge_pkg::*;

    localparam int AW          = `AHB_ADDR_WIDTH;
    localparam int RST_TIMEOUT = 50;

    logic                       s_ahb = 1'b0;
    logic                       rst = 1'b1;
    logic                       hsel;
    logic [`AHB_ADDR_WIDTH-1:0] haddr;
    logic [1:0]                 htrans;
    logic                       hwrite;
    logic [2:0]                 hsize;
    logic [`AHB_DATA_WIDTH-1:0] hwdata;
    logic [`AHB_DATA_WIDTH-1:0] hrdata;

    integer seed = 32'h1b75b1e8;

    // Expected memory content, updated at each qualified write address phase.
    data_t ref_mem [`MEM_DEPTH];

    ahb_mem_bridge dut0 (
        .s_ahb  (s_ahb),
        .rst    (rst),
        .hsel   (hsel),
        .haddr  (haddr),
        .htrans (htrans),
        .hwrite (hwrite),
        .hsize  (hsize),
        .hwdata (hwdata),
        .hrdata (hrdata)
    );

    always #5 s_ahb = ~s_ahb;

    initial begin
        repeat (10) @(negedge s_ahb);
        rst = 1'b0;
    end

    function automatic data_t rand_data();
        data_t d;
        for (int k = 0; k < `AHB_DATA_WIDTH / 32; k++) begin
            d[k*32 +: 32] = $random(seed);
        end
        return d;
    endfunction

    // Lanes from the offset for 2**size bytes, cut at the top lane.
    function automatic data_t write_mask(input int off, input int size);
        data_t m;
        m = '0;
        for (int b = 0; b < LANES; b++) begin
            if (b >= off && b < off + (1 << size)) begin
                m[b*8 +: 8] = 8'hff;
            end
        end
        return m;
    endfunction

    task automatic model_write(input int word, input int off, input int size, input data_t data);
        data_t m;
        m = write_mask(off, size);
        ref_mem[word_addr_t'(word)] = (ref_mem[word_addr_t'(word)] & ~m) | (data & m);
    endtask

    task automatic check_data(input string name, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic drive_addr(input logic sel, input logic [1:0] trans, input logic write,
                              input int size, input int word, input int off);
        hsel   = sel;
        htrans = trans;
        hwrite = write;
        hsize  = 3'(size);
        haddr  = AW'(word * LANES + off);
    endtask

    task automatic drive_idle();
        hsel   = 1'b0;
        htrans = HTRANS_IDLE;
        hwrite = 1'b0;
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (rst === 1'b1 && cycles < RST_TIMEOUT) begin
            @(posedge s_ahb);
            cycles++;
        end
        if (rst !== 1'b0) begin
            $display("Timeout: reset still asserted after %0d cycles", cycles);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic ahb_write(input logic sel, input logic [1:0] trans, input int word,
                             input int off, input int size, input data_t data);
        @(negedge s_ahb);
        drive_addr(sel, trans, 1'b1, size, word, off);
        if (sel && (trans == HTRANS_NONSEQ || trans == HTRANS_SEQ)) begin
            model_write(word, off, size, data);
        end
        @(negedge s_ahb);
        drive_idle();
        hwdata = data;
    endtask

    task automatic ahb_read(input int word, input int off, output data_t data);
        @(negedge s_ahb);
        drive_addr(1'b1, HTRANS_NONSEQ, 1'b0, 3, word, off);
        @(negedge s_ahb);
        drive_idle();
        data = hrdata;
    endtask

    task automatic read_and_check(input string name, input int word);
        data_t rd;
        ahb_read(word, 0, rd);
        check_data(name, ref_mem[word_addr_t'(word)], rd);
    endtask

    // The read address phase sits in the write's data phase.
    task automatic write_then_read(input string name, input int wword, input int off,
                                   input int size, input data_t wdata, input int rword);
        data_t expected;
        @(negedge s_ahb);
        drive_addr(1'b1, HTRANS_NONSEQ, 1'b1, size, wword, off);
        model_write(wword, off, size, wdata);
        @(negedge s_ahb);
        hwdata = wdata;
        drive_addr(1'b1, HTRANS_SEQ, 1'b0, 3, rword, 0);
        expected = ref_mem[word_addr_t'(rword)];
        @(negedge s_ahb);
        drive_idle();
        check_data(name, expected, hrdata);
    endtask

    task automatic test_full_words();
        for (int k = 0; k < 8; k++) begin
            ahb_write(1'b1, HTRANS_NONSEQ, k * 61 + 3, 0, 3, rand_data());
        end
        for (int k = 0; k < 8; k++) begin
            read_and_check("full_words", k * 61 + 3);
        end
        // Word indices past the depth wrap around.
        ahb_write(1'b1, HTRANS_NONSEQ, `MEM_DEPTH + 100, 0, 3, rand_data());
        read_and_check("address_wrap", 100);
    endtask

    task automatic test_partial_lanes();
        ahb_write(1'b1, HTRANS_NONSEQ, 40, 0, 3, rand_data());
        for (int size = 0; size < 3; size++) begin
            for (int off = 0; off < LANES; off += (1 << size)) begin
                ahb_write(1'b1, HTRANS_NONSEQ, 40, off, size, rand_data());
                read_and_check("partial_lanes", 40);
            end
        end
        ahb_write(1'b1, HTRANS_NONSEQ, 40, LANES - 2, 2, rand_data());
        read_and_check("truncated_lanes", 40);
        ahb_write(1'b1, HTRANS_SEQ, 40, 3, 3, rand_data());
        read_and_check("truncated_lanes", 40);
    endtask

    task automatic test_forwarding();
        ahb_write(1'b1, HTRANS_NONSEQ, 20, 0, 3, rand_data());
        ahb_write(1'b1, HTRANS_NONSEQ, 21, 0, 3, rand_data());
        write_then_read("forward_same_word", 20, 2, 1, rand_data(), 20);
        write_then_read("forward_same_word", 20, 5, 0, rand_data(), 20);
        write_then_read("forward_full_word", 20, 0, 3, rand_data(), 20);
        write_then_read("forward_other_word", 20, 4, 2, rand_data(), 21);
        read_and_check("forward_after", 20);
    endtask

    task automatic test_ignored_transfers();
        ahb_write(1'b1, HTRANS_NONSEQ, 9, 0, 3, rand_data());
        ahb_write(1'b0, HTRANS_NONSEQ, 9, 0, 3, rand_data());
        read_and_check("hsel_low", 9);
        ahb_write(1'b1, HTRANS_IDLE, 9, 0, 3, rand_data());
        read_and_check("htrans_idle", 9);
        ahb_write(1'b1, HTRANS_BUSY, 9, 2, 1, rand_data());
        read_and_check("htrans_busy", 9);
    endtask

    // One address phase per cycle, so reads often land in a write's data phase.
    task automatic test_random_mix();
        int    word;
        int    off;
        int    size;
        int    is_wr;
        logic  pend_wr;
        logic  pend_rd;
        data_t pend_data;
        data_t pend_exp;
        for (int k = 0; k < 16; k++) begin
            ahb_write(1'b1, HTRANS_NONSEQ, k, 0, 3, rand_data());
        end
        pend_wr = 1'b0;
        pend_rd = 1'b0;
        for (int n = 0; n < 200; n++) begin
            @(negedge s_ahb);
            if (pend_rd) begin
                check_data("random_mix", pend_exp, hrdata);
            end
            if (pend_wr) begin
                hwdata = pend_data;
            end
            word  = {$random(seed)} % 16;
            off   = {$random(seed)} % LANES;
            size  = {$random(seed)} % 4;
            is_wr = {$random(seed)} % 2;
            if (is_wr != 0) begin
                pend_data = rand_data();
                model_write(word, off, size, pend_data);
                drive_addr(1'b1, (n % 3 == 0) ? HTRANS_SEQ : HTRANS_NONSEQ, 1'b1,
                           size, word, off);
            end else begin
                pend_exp = ref_mem[word_addr_t'(word)];
                drive_addr(1'b1, HTRANS_NONSEQ, 1'b0, size, word, off);
            end
            pend_wr = (is_wr != 0);
            pend_rd = (is_wr == 0);
        end
        @(negedge s_ahb);
        if (pend_rd) begin
            check_data("random_mix", pend_exp, hrdata);
        end
        if (pend_wr) begin
            hwdata = pend_data;
        end
        drive_idle();
        @(negedge s_ahb);
    endtask

    initial begin
        hsel   = 1'b0;
        haddr  = '0;
        htrans = HTRANS_IDLE;
        hwrite = 1'b0;
        hsize  = 3'd0;
        hwdata = '0;
        wait_reset_release();
        check_data("reset", '0, hrdata);
        test_full_words();
        test_partial_lanes();
        test_forwarding();
        test_ignored_transfers();
        test_random_mix();
        repeat (2) @(negedge s_ahb);
        if (dut0.u_decode.chk0.fail_count == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("Request checker reported %0d assertion failures",
                     dut0.u_decode.chk0.fail_count);
            $display("sim failed");
            $fatal(1);
        end
    end

endmodule

//--- ahb_mem_bridge.f
+incdir+hw
hw/ahb_bridge_pkg.sv
hw/mem_req_if.sv
hw/ahb_addr_decode.sv
hw/byte_lane_sram.sv
hw/read_forward_merge.sv
hw/ahb_mem_bridge.sv
verification/ahb_mem_bridge_chk.sv
verification/ahb_mem_bridge_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= ahb_mem_bridge_tb
FILELIST  ?= ahb_mem_bridge.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard hw/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	-$(BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -q '^sim passed$$' $(LOG) || { echo "Test failed, see $(LOG)"; exit 1; }
	@echo "Test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
